/* src/ld_store_pkg.sv */
// ----------------------------------------
// Table codes cover only the LD (nn),dd group.
// ----------------------------------------
`default_nettype none

package ld_store_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [3:0]  step_t;
    typedef logic [7:0]  itable_t;

    // Coded as the dd field of the opcode.
    typedef enum logic [1:0] {
        PAIR_BC = 2'b00,
        PAIR_DE = 2'b01,
        PAIR_HL = 2'b10,
        PAIR_SP = 2'b11
    } pair_sel_e;

    localparam itable_t ITABLE_IDLE     = 8'b0000_0000;
    localparam itable_t ITABLE_DISPATCH = 8'b1000_0000; // Low two bits carry dd.
    localparam itable_t ITABLE_EXECUTE  = 8'b1000_0100; // Low two bits carry dd.

    localparam step_t STEP_FIRST = 4'd3;
    localparam step_t STEP_LAST  = 4'd8;

endpackage

`default_nettype wire

/* src/micro_step_sequencer.sv */
// ----------------------------------------
// Command data must hold while cmd_valid is high.
// Steps hold only on a memory stall.
// ----------------------------------------
`default_nettype none

module micro_step_sequencer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            cmd_valid,
    input  wire ld_store_pkg::pair_sel_e   cmd_pair,
    input  wire                            reset_step,
    input  wire                            clear_itable,
    input  wire                            mem_stall,
    output logic                           cmd_ready,
    output ld_store_pkg::itable_t          itable,
    output ld_store_pkg::step_t            step
);

    logic                  cmd_accept;
    ld_store_pkg::itable_t dispatch_code;
    ld_store_pkg::itable_t execute_code;
    ld_store_pkg::step_t   step_next;

    // Only one instruction in flight.
    assign cmd_ready  = (itable == ld_store_pkg::ITABLE_IDLE);
    assign cmd_accept = cmd_valid && cmd_ready;

    // dd rides in the low two bits of both entries.
    assign dispatch_code = ld_store_pkg::ITABLE_DISPATCH
                           | ld_store_pkg::itable_t'(cmd_pair);
    assign execute_code  = ld_store_pkg::ITABLE_EXECUTE
                           | {6'b00_0000, itable[1:0]};

    assign step_next = ld_store_pkg::step_t'(step + 4'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            itable <= ld_store_pkg::ITABLE_IDLE;
            step   <= '0;
        end else if (cmd_accept) begin
            itable <= dispatch_code;
            step   <= '0;
        end else if (!mem_stall) begin
            if (clear_itable) begin
                // Last write done, back to idle.
                itable <= ld_store_pkg::ITABLE_IDLE;
                step   <= '0;
            end else if (reset_step) begin
                itable <= execute_code; // Dispatch cycle.
                step   <= ld_store_pkg::STEP_FIRST;
            end else if (itable != ld_store_pkg::ITABLE_IDLE) begin
                step <= step_next;
            end
        end
    end

endmodule

`default_nettype wire

/* src/ld_nn_dd_decoder.sv */
// ----------------------------------------
// Pure decode; only the 10000xxx table group is
// recognised, all other codes give no strobes.
// ----------------------------------------
`default_nettype none

module ld_nn_dd_decoder (
    input  wire ld_store_pkg::itable_t itable,
    input  wire ld_store_pkg::step_t   step,
    output logic [8:0]                 decoded_step,
    output logic                       set_cmr,
    output logic                       w0,
    output logic                       w1,
    output logic                       w2,
    output logic                       byte_sel_high,
    output ld_store_pkg::pair_sel_e    pair_sel,
    output logic                       select_adt1,
    output logic                       select_temp_addr,
    output logic                       reset_step,
    output logic                       clear_itable
);

    logic group_hit;
    logic dispatch;
    logic execute;
    logic steps_3_5;
    logic steps_6_8;

    // Upper five bits pick the instruction group.
    assign group_hit = (itable[7:3] == ld_store_pkg::ITABLE_DISPATCH[7:3]);

    // Bit 2 splits the dispatch entry from the execute entry.
    assign dispatch = group_hit && !itable[2];
    assign execute  = group_hit && itable[2];

    // One-hot step, only while executing.
    always_comb begin
        decoded_step = '0;
        if (execute && step <= ld_store_pkg::STEP_LAST) begin
            decoded_step[step] = 1'b1;
        end
    end

    assign set_cmr = dispatch;

    // Write phases repeat once per byte.
    assign w0 = decoded_step[3] | decoded_step[6];
    assign w1 = decoded_step[4] | decoded_step[7];
    assign w2 = decoded_step[5] | decoded_step[ld_store_pkg::STEP_LAST];

    assign steps_3_5 = decoded_step[ld_store_pkg::STEP_FIRST]
                       | decoded_step[4]
                       | decoded_step[5];
    assign steps_6_8 = decoded_step[6]
                       | decoded_step[7]
                       | decoded_step[ld_store_pkg::STEP_LAST];

    // High byte goes out in the second half.
    assign byte_sel_high    = steps_6_8;
    assign select_adt1      = steps_6_8; // nn+1 for the high byte.
    assign select_temp_addr = steps_3_5 | steps_6_8;

    assign pair_sel = ld_store_pkg::pair_sel_e'(itable[1:0]);

    assign reset_step   = set_cmr | decoded_step[ld_store_pkg::STEP_LAST];
    assign clear_itable = decoded_step[ld_store_pkg::STEP_LAST];

endmodule

`default_nettype wire

/* src/register_pairs.sv */
// ----------------------------------------
// Loads land on the next edge; the read is
// combinational.
// ----------------------------------------
`default_nettype none

module register_pairs #(
    parameter ld_store_pkg::word_t PAIR_RESET = '0
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            load_valid,
    input  wire ld_store_pkg::pair_sel_e   load_pair,
    input  wire ld_store_pkg::word_t       load_data,
    input  wire ld_store_pkg::pair_sel_e   pair_sel,
    input  wire                            byte_sel_high,
    output ld_store_pkg::byte_t            read_byte
);

    // Indexed by dd.
    ld_store_pkg::word_t pairs [4];
    ld_store_pkg::word_t sel_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                pairs[i] <= PAIR_RESET;
            end
        end else if (load_valid) begin
            pairs[load_pair] <= load_data;
        end
    end

    assign sel_word  = pairs[pair_sel];
    assign read_byte = byte_sel_high ? sel_word[15:8] : sel_word[7:0]; // B/D/H/S or C/E/L/P.

endmodule

`default_nettype wire

/* src/store_bus_unit.sv */
// ----------------------------------------
// nn+1 wraps from FFFF to 0000.
// ----------------------------------------
`default_nettype none

module store_bus_unit (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        cmd_accept,
    input  wire ld_store_pkg::addr_t   cmd_addr,
    input  wire                        w2,
    input  wire                        select_adt1,
    input  wire                        select_temp_addr,
    input  wire ld_store_pkg::byte_t   read_byte,
    input  wire                        mem_ready,
    output logic                       mem_valid,
    output ld_store_pkg::addr_t        mem_addr,
    output ld_store_pkg::byte_t        mem_data,
    output logic                       mem_stall
);

    ld_store_pkg::addr_t temp_addr;
    ld_store_pkg::addr_t temp_addr_inc;
    ld_store_pkg::addr_t temp_sel;

    // Holds nn for the whole instruction.
    always_ff @(posedge clk) begin
        if (rst) begin
            temp_addr <= '0;
        end else if (cmd_accept) begin
            temp_addr <= cmd_addr;
        end
    end

    assign temp_addr_inc = ld_store_pkg::addr_t'(temp_addr + 16'd1);
    assign temp_sel      = select_adt1 ? temp_addr_inc : temp_addr;

    // Write request lives for the whole w2 step.
    assign mem_valid = w2;
    assign mem_addr  = select_temp_addr ? temp_sel : '0;
    assign mem_data  = read_byte;

    assign mem_stall = mem_valid && !mem_ready; // Step waits here.

endmodule

`default_nettype wire

/* src/ld_store_core.sv */
// ----------------------------------------
// Issue preloads only while cmd_ready is high.
// ----------------------------------------
`default_nettype none

module ld_store_core #(
    parameter ld_store_pkg::word_t PAIR_RESET = '0
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            cmd_valid,
    output logic                           cmd_ready,
    input  wire ld_store_pkg::pair_sel_e   cmd_pair,
    input  wire ld_store_pkg::addr_t       cmd_addr,
    input  wire                            load_valid,
    input  wire ld_store_pkg::pair_sel_e   load_pair,
    input  wire ld_store_pkg::word_t       load_data,
    output logic                           mem_valid,
    input  wire                            mem_ready,
    output ld_store_pkg::addr_t            mem_addr,
    output ld_store_pkg::byte_t            mem_data
);

    ld_store_pkg::itable_t   itable;
    ld_store_pkg::step_t     step;
    ld_store_pkg::pair_sel_e pair_sel;
    ld_store_pkg::byte_t     read_byte;
    logic [8:0]              decoded_step;
    logic                    w2;
    logic                    byte_sel_high;
    logic                    select_adt1;
    logic                    select_temp_addr;
    logic                    reset_step;
    logic                    clear_itable;
    logic                    mem_stall;
    logic                    cmd_accept;

    // Both the sequencer and the bus unit act on this edge.
    assign cmd_accept = cmd_valid && cmd_ready;

    micro_step_sequencer micro_step_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_pair     (cmd_pair),
        .reset_step   (reset_step),
        .clear_itable (clear_itable),
        .mem_stall    (mem_stall),
        .cmd_ready    (cmd_ready),
        .itable       (itable),
        .step         (step)
    );

    ld_nn_dd_decoder ld_nn_dd_decoder_i (
        .itable           (itable),
        .step             (step),
        .decoded_step     (decoded_step),
        .set_cmr          (),
        .w0               (),            // No address latch cycle in this core.
        .w1               (),
        .w2               (w2),
        .byte_sel_high    (byte_sel_high),
        .pair_sel         (pair_sel),
        .select_adt1      (select_adt1),
        .select_temp_addr (select_temp_addr),
        .reset_step       (reset_step),
        .clear_itable     (clear_itable)
    );

    register_pairs #(
        .PAIR_RESET (PAIR_RESET)
    ) register_pairs_i (
        .clk           (clk),
        .rst           (rst),
        .load_valid    (load_valid),
        .load_pair     (load_pair),
        .load_data     (load_data),
        .pair_sel      (pair_sel),
        .byte_sel_high (byte_sel_high),
        .read_byte     (read_byte)
    );

    store_bus_unit store_bus_unit_i (
        .clk              (clk),
        .rst              (rst),
        .cmd_accept       (cmd_accept),
        .cmd_addr         (cmd_addr),
        .w2               (w2),
        .select_adt1      (select_adt1),
        .select_temp_addr (select_temp_addr),
        .read_byte        (read_byte),
        .mem_ready        (mem_ready),
        .mem_valid        (mem_valid),
        .mem_addr         (mem_addr),
        .mem_data         (mem_data),
        .mem_stall        (mem_stall)
    );

endmodule

`default_nettype wire

/* bench/ld_store_asserts.sv */
// ----------------------------------------
// Bound into ld_store_core, where the sequencer, decoder
// and bus unit nets all meet.
// ----------------------------------------
`default_nettype none

module ld_store_asserts (
    input wire                        clk,
    input wire                        rst,
    input wire [8:0]                  decoded_step,
    input wire                        cmd_ready,
    input wire ld_store_pkg::itable_t itable,
    input wire                        mem_valid,
    input wire                        mem_ready,
    input wire ld_store_pkg::addr_t   mem_addr,
    input wire ld_store_pkg::byte_t   mem_data
);

    // Execution only ever visits steps 3 to 8.
    step_one_hot: assert property (@(posedge clk) disable iff (rst)
        itable[7:2] == ld_store_pkg::ITABLE_EXECUTE[7:2]
        |-> $onehot(decoded_step) && decoded_step[2:0] == 3'b000)
        else $error("decoded_step is not one-hot on steps 3 to 8: %b", decoded_step);

    // A stalled write keeps its address and data.
    write_held: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
        else $error("memory write changed before mem_ready");

    ready_after_last: assert property (@(posedge clk) disable iff (rst)
        decoded_step[ld_store_pkg::STEP_LAST] && mem_ready |=> cmd_ready)
        else $error("cmd_ready not high after the last write of an instruction");

endmodule

bind ld_store_core ld_store_asserts ld_store_asserts_i (
    .clk          (clk),
    .rst          (rst),
    .decoded_step (decoded_step),
    .cmd_ready    (cmd_ready),
    .itable       (itable),
    .mem_valid    (mem_valid),
    .mem_ready    (mem_ready),
    .mem_addr     (mem_addr),
    .mem_data     (mem_data)
);

`default_nettype wire

/* bench/ld_store_tb.sv */
// ----------------------------------------
// Run from the project root; cases come from bench/ld_store_cases.txt.
// Preloads are issued only while cmd_ready is high.
// ----------------------------------------
`default_nettype none

module ld_store_tb;

    localparam int CLK_PERIOD       = 10;
    localparam int WAIT_LIMIT       = 60;  // Cycles allowed for one handshake wait.
    localparam int NO_STALL_LATENCY = 3;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cmd_valid;
    logic                    cmd_ready;
    ld_store_pkg::pair_sel_e cmd_pair;
    ld_store_pkg::addr_t     cmd_addr;
    logic                    load_valid;
    ld_store_pkg::pair_sel_e load_pair;
    ld_store_pkg::word_t     load_data;
    logic                    mem_valid;
    logic                    mem_ready;
    ld_store_pkg::addr_t     mem_addr;
    ld_store_pkg::byte_t     mem_data;

    // One case table entry per L or C line.
    byte                 case_op [$];
    logic [1:0]          case_pair [$];
    logic [15:0]         case_value [$];
    ld_store_pkg::addr_t exp_addr0 [$];
    ld_store_pkg::byte_t exp_data0 [$];
    ld_store_pkg::addr_t exp_addr1 [$];
    ld_store_pkg::byte_t exp_data1 [$];
    bit                  case_no_stall [$];

    // Completed memory writes in order.
    ld_store_pkg::addr_t wr_addr [$];
    ld_store_pkg::byte_t wr_data [$];

    int                  mismatches;
    int                  other_errors;
    int                  cmd_count;
    bit                  cases_loaded;
    bit                  no_stall;
    logic [31:0]         rng_state;
    logic                pend;
    ld_store_pkg::addr_t pend_addr;
    ld_store_pkg::byte_t pend_data;

    ld_store_core ld_store_core_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_pair   (cmd_pair),
        .cmd_addr   (cmd_addr),
        .load_valid (load_valid),
        .load_pair  (load_pair),
        .load_data  (load_data),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory ready changes only on the falling edge.
    always @(negedge clk) begin
        rng_state = xorshift32(rng_state);
        mem_ready = no_stall ? 1'b1 : (rng_state[1:0] != 2'b00); // About one cycle in four stalls.
    end

    // Write monitor sees the values that the rising edge acts on.
    always @(posedge clk) begin
        if (!rst) begin
            if (pend && !(mem_valid && mem_addr == pend_addr && mem_data == pend_data)) begin
                $display("MISMATCH t=%0t: stalled write %h to %h changed to valid=%b %h to %h",
                         $time, pend_data, pend_addr, mem_valid, mem_data, mem_addr);
                mismatches++;
            end
            if (mem_valid && mem_ready) begin
                wr_addr.push_back(mem_addr);
                wr_data.push_back(mem_data);
            end
            pend      = mem_valid && !mem_ready;
            pend_addr = mem_addr;
            pend_data = mem_data;
        end
    end

    task automatic read_cases(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [15:0] p;
        logic [15:0] v;
        logic [15:0] a0;
        logic [15:0] d0;
        logic [15:0] a1;
        logic [15:0] d1;
        logic [15:0] ns;
        ok = 1'b0;
        fd = $fopen("bench/ld_store_cases.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open bench/ld_store_cases.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    op = line.getc(0);
                    if (op == "L") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", p, v);
                        if (n != 2) begin
                            $display("ERROR: malformed preload line: %s", line);
                            other_errors++;
                        end else begin
                            case_op.push_back(op);
                            case_pair.push_back(p[1:0]);
                            case_value.push_back(v);
                            exp_addr0.push_back('0);
                            exp_data0.push_back('0);
                            exp_addr1.push_back('0);
                            exp_data1.push_back('0);
                            case_no_stall.push_back(1'b1);
                        end
                    end else if (op == "C") begin
                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h %h",
                                    p, v, a0, d0, a1, d1, ns);
                        if (n != 7) begin
                            $display("ERROR: malformed command line: %s", line);
                            other_errors++;
                        end else begin
                            case_op.push_back(op);
                            case_pair.push_back(p[1:0]);
                            case_value.push_back(v);
                            exp_addr0.push_back(a0);
                            exp_data0.push_back(d0[7:0]);
                            exp_addr1.push_back(a1);
                            exp_data1.push_back(d1[7:0]);
                            case_no_stall.push_back(ns != 16'h0);
                        end
                    end
                end
            end
            $fclose(fd);
            ok = (case_op.size() > 0);
        end
    endtask

    task automatic wait_cmd_ready(output bit seen);
        int waited;
        waited = 0;
        while (!cmd_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        seen = cmd_ready;
    endtask

    task automatic apply_preload(input logic [1:0] p, input logic [15:0] v);
        bit seen;
        wait_cmd_ready(seen);
        if (!seen) begin
            $display("ERROR: t=%0t cmd_ready stayed low, preload of pair %0d skipped", $time, p);
            other_errors++;
        end else begin
            load_valid = 1'b1;
            load_pair  = ld_store_pkg::pair_sel_e'(p);
            load_data  = v;
            @(negedge clk);
            load_valid = 1'b0;
        end
    endtask

    task automatic compare_write(input string what,
                                 input ld_store_pkg::addr_t got_a,
                                 input ld_store_pkg::byte_t got_d,
                                 input ld_store_pkg::addr_t exp_a,
                                 input ld_store_pkg::byte_t exp_d);
        if (got_a !== exp_a || got_d !== exp_d) begin
            $display("MISMATCH t=%0t: %s wrote %h to %h, expected %h to %h",
                     $time, what, got_d, got_a, exp_d, exp_a);
            mismatches++;
        end
    endtask

    task automatic run_store(input int idx);
        bit seen;
        int waited;
        int latency;
        int base;
        base      = wr_addr.size();
        no_stall  = case_no_stall[idx];
        cmd_valid = 1'b1;
        cmd_pair  = ld_store_pkg::pair_sel_e'(case_pair[idx]);
        cmd_addr  = case_value[idx];
        wait_cmd_ready(seen);
        if (!seen) begin
            $display("ERROR: t=%0t command %0d was never accepted", $time, idx);
            other_errors++;
            cmd_valid = 1'b0;
        end else begin
            @(negedge clk); // Accepted on the edge just passed.
            cmd_valid = 1'b0;
            latency   = 0;
            while (!mem_valid && latency < WAIT_LIMIT) begin
                @(negedge clk);
                latency++;
            end
            if (no_stall && latency != NO_STALL_LATENCY) begin
                $display("MISMATCH t=%0t: command %0d first write after %0d cycles, expected %0d",
                         $time, idx, latency, NO_STALL_LATENCY);
                mismatches++;
            end
            waited = 0;
            while (wr_addr.size() < base + 2 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (wr_addr.size() < base + 2) begin
                $display("ERROR: t=%0t command %0d completed only %0d of its 2 writes",
                         $time, idx, wr_addr.size() - base);
                other_errors++;
            end else begin
                if (!cmd_ready) begin
                    $display("MISMATCH t=%0t: command %0d left cmd_ready low after its last write",
                             $time, idx);
                    mismatches++;
                end
                compare_write($sformatf("command %0d low byte", idx), wr_addr[base],
                              wr_data[base], exp_addr0[idx], exp_data0[idx]);
                compare_write($sformatf("command %0d high byte", idx), wr_addr[base + 1],
                              wr_data[base + 1], exp_addr1[idx], exp_data1[idx]);
            end
        end
        cmd_count++;
    endtask

    initial begin
        bit ok;
        rst          = 1'b1;
        cmd_valid    = 1'b0;
        cmd_pair     = ld_store_pkg::PAIR_BC;
        cmd_addr     = '0;
        load_valid   = 1'b0;
        load_pair    = ld_store_pkg::PAIR_BC;
        load_data    = '0;
        mem_ready    = 1'b0;
        no_stall     = 1'b1;
        rng_state    = 32'd50;
        pend         = 1'b0;
        pend_addr    = '0;
        pend_data    = '0;
        mismatches   = 0;
        other_errors = 0;
        cmd_count    = 0;
        cases_loaded = 1'b0;
        read_cases(ok);
        cases_loaded = ok;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (ok) begin
            for (int i = 0; i < case_op.size(); i++) begin
                if (case_op[i] == "L") begin
                    apply_preload(case_pair[i], case_value[i]);
                end else begin
                    run_store(i);
                end
            end
            repeat (4) @(negedge clk); // Room for a stray third write.
            if (wr_addr.size() != 2 * cmd_count) begin
                $display("ERROR: %0d memory writes seen for %0d commands",
                         wr_addr.size(), cmd_count);
                other_errors++;
            end
        end
        $display("Run finished: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Seven cycles per case, eight times over for stalls, plus reset.
    initial begin
        int limit;
        wait (cases_loaded);
        limit = (2 + case_op.size() * 7 * 8) * CLK_PERIOD;
        #(limit);
        $display("ERROR: watchdog expired at t=%0t, the DUT stopped making progress", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/ld_store_cases.txt */
# L pair value : preload, pair is dd (0 BC, 1 DE, 2 HL, 3 SP), value in hex
# C pair nn addr0 data0 addr1 data1 no_stall : store with its two expected writes
L 0 1234
L 1 5678
L 2 9abc
L 3 def0
C 0 1000 1000 34 1001 12 1
C 1 2000 2000 78 2001 56 1
C 2 3000 3000 bc 3001 9a 1
C 3 4000 4000 f0 4001 de 1
C 2 ffff ffff bc 0000 9a 1
C 1 80ff 80ff 78 8100 56 0
C 0 0010 0010 34 0011 12 0
C 3 7ffe 7ffe f0 7fff de 0
L 1 a55a
C 1 5000 5000 5a 5001 a5 0
C 0 5002 5002 34 5003 12 0
C 2 5004 5004 bc 5005 9a 0
L 3 0001
C 3 ffff ffff 01 0000 00 0
C 1 c000 c000 5a c001 a5 1

/* build.f */
src/ld_store_pkg.sv
src/micro_step_sequencer.sv
src/ld_nn_dd_decoder.sv
src/register_pairs.sv
src/store_bus_unit.sv
src/ld_store_core.sv
bench/ld_store_asserts.sv
bench/ld_store_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the LD (nn),dd testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module ld_store_tb -o ld_store_sim

if ! ./obj_dir/ld_store_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status."
    exit 1
fi

cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi

exit 0
